//--- src/irq_pkg.sv
`default_nettype none

// shared sizes and types for the interrupt controller
package irq_pkg;

   // source count and id width
   localparam int NUM_IRQ    = 16;
   localparam int IRQ_ID_W   = $clog2(NUM_IRQ);

   // configuration address width
   localparam int CSR_ADDR_W = 2;

   // register map
   localparam logic [CSR_ADDR_W-1:0] ADDR_MASK = CSR_ADDR_W'(0);
   localparam logic [CSR_ADDR_W-1:0] ADDR_CTRL = CSR_ADDR_W'(1);

   // control register view
   typedef struct packed
   {
      // upper bits ignored on write
      logic [NUM_IRQ-2:0] rsvd;
      // master interrupt enable
      logic               global_en;
   } csr_ctrl_t;

   // one write word, read as mask or as control
   // depending on the address it goes to
   typedef union packed
   {
      // one enable bit per source
      logic [NUM_IRQ-1:0] mask;
      csr_ctrl_t          ctrl;
   } csr_data_u;

   // configuration write strobe bundle
   typedef struct packed
   {
      // single cycle write strobe
      logic                  we;
      logic [CSR_ADDR_W-1:0] addr;
      csr_data_u             data;
   } csr_wr_t;

   // interrupt output toward the cpu side
   typedef struct packed
   {
      // level, held until ack
      logic                valid;
      // source number of the presented interrupt
      logic [IRQ_ID_W-1:0] id;
   } irq_out_t;

endpackage : irq_pkg

`default_nettype wire

//--- src/encode_one_hot.sv
`timescale 1ns/1ps
`default_nettype none

// one-hot word to binary address
//   0001 -> 0, v=1
//   0100 -> 2, v=1
//   0000 -> 0, v=0
// more than one bit set gives a meaningless address
//
// built as a tree of ORs
// each level splits the word in halves and the upper
// half's valid bit becomes the next address bit
module encode_one_hot
#(
   parameter int  width_p   = 8,
   localparam int addr_w_lp = (width_p == 1) ? 1 : $clog2(width_p)
)
(
   input  logic [width_p-1:0]   i,
   output logic [addr_w_lp-1:0] addr_o,
   output logic                 v_o
);

   localparam int half_width_lp    = width_p >> 1;
   localparam int aligned_width_lp = 1 << $clog2(width_p);
   // address width of each half
   localparam int half_addr_w_lp   = (half_width_lp <= 1) ? 1 : $clog2(half_width_lp);

   if (width_p == 1)
   begin : g_single
      // only one possible position
      assign v_o    = i[0];
      assign addr_o = 1'b0;
   end
   else if (width_p == 2)
   begin : g_pair
      // leaf of the tree
      assign v_o    = |i;
      assign addr_o = i[1];
   end
   else if (width_p != aligned_width_lp)
   begin : g_pad
      // pad once at the top so every inner node is a power of two
      logic [$clog2(aligned_width_lp)-1:0] aligned_addr;

      encode_one_hot #(.width_p(aligned_width_lp)) u_aligned
      (
         .i      ({{(aligned_width_lp - width_p){1'b0}}, i}),
         .addr_o (aligned_addr),
         .v_o    (v_o)
      );

      assign addr_o = aligned_addr[addr_w_lp-1:0];
   end
   else
   begin : g_split
      logic [1:0][half_addr_w_lp-1:0] addrs;
      logic [1:0]                     vs;

      encode_one_hot #(.width_p(half_width_lp)) u_lo
      (
         .i      (i[0 +: half_width_lp]),
         .addr_o (addrs[0]),
         .v_o    (vs[0])
      );

      encode_one_hot #(.width_p(half_width_lp)) u_hi
      (
         .i      (i[half_width_lp +: half_width_lp]),
         .addr_o (addrs[1]),
         .v_o    (vs[1])
      );

      // at most one half is nonzero, so OR merges the low bits
      assign v_o    = |vs;
      assign addr_o = {vs[1], addrs[0] | addrs[1]};
   end

   // input must be one-hot or zero
   always_comb
   begin
      if (!$isunknown(i))
      begin
         a_one_hot_in : assert final ($countones(i) <= 1)
            else $error("encode_one_hot: input %b is not one-hot", i);
      end
   end

endmodule : encode_one_hot

`default_nettype wire

//--- src/priority_pick.sv
`timescale 1ns/1ps
`default_nettype none

// fixed priority picker
// lowest numbered eligible request wins
module priority_pick
#(
   parameter int width_p = 16
)
(
   input  logic [width_p-1:0] pending_i,
   input  logic [width_p-1:0] enable_i,
   input  logic               global_en_i,
   output logic [width_p-1:0] grant_o,
   output logic               any_o
);

   // requests that survive both enables
   logic [width_p-1:0] eligible;

   // master enable gates every source
   assign eligible = pending_i & enable_i & {width_p{global_en_i}};

   // x & -x keeps only the lowest set bit
   // the carry stops at the first one from the bottom
   assign grant_o = eligible & (~eligible + width_p'(1));

   // something is ready to present
   assign any_o = |eligible;

   // never more than one grant
   always_comb
   begin
      if (!$isunknown(grant_o))
      begin
         a_grant_one_hot : assert final ($onehot0(grant_o))
            else $error("priority_pick: grant %b not one-hot", grant_o);
      end
   end

endmodule : priority_pick

`default_nettype wire

//--- src/irq_pending.sv
`timescale 1ns/1ps
`default_nettype none

// sticky pending bits
// one per interrupt source
module irq_pending
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // single cycle request pulses
   input  logic [irq_pkg::NUM_IRQ-1:0] src_i,
   // one-hot clear from the output stage
   input  logic [irq_pkg::NUM_IRQ-1:0] clear_i,
   output logic [irq_pkg::NUM_IRQ-1:0] pending_o
);

   import irq_pkg::*;

   logic [NUM_IRQ-1:0] pending_r;
   logic [NUM_IRQ-1:0] pending_nxt;

   // clear first, then set
   // a pulse landing with its own clear keeps the bit
   assign pending_nxt = (pending_r & ~clear_i) | src_i;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         pending_r <= '0;
      end
      else
      begin
         pending_r <= pending_nxt;
      end
   end

   assign pending_o = pending_r;

   // only the presented source is ever cleared
   a_clear_one_hot : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(clear_i)
   ) else $error("irq_pending: clear %b has several bits", clear_i);

   // a clear must hit a bit that is actually pending
   a_clear_hits_pending : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (clear_i != '0) |-> ((clear_i & pending_r) == clear_i)
   ) else $error("irq_pending: clear %b on idle source", clear_i);

endmodule : irq_pending

`default_nettype wire

//--- src/irq_csr.sv
`timescale 1ns/1ps
`default_nettype none

// configuration registers
//   ADDR_MASK  per source enable mask
//   ADDR_CTRL  global enable in bit 0
// write only, no readback path
module irq_csr
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // write strobe, address and data
   input  irq_pkg::csr_wr_t            csr_i,
   output logic [irq_pkg::NUM_IRQ-1:0] enable_mask_o,
   output logic                        global_en_o
);

   import irq_pkg::*;

   // stored configuration
   logic [NUM_IRQ-1:0] enable_mask_r;
   logic               global_en_r;

   // per register write enables
   logic               wr_mask;
   logic               wr_ctrl;

   // address decode
   // anything outside the map is dropped
   always_comb
   begin
      wr_mask = 1'b0;
      wr_ctrl = 1'b0;
      if (csr_i.we)
      begin
         case (csr_i.addr)
            ADDR_MASK : wr_mask = 1'b1;
            ADDR_CTRL : wr_ctrl = 1'b1;
            default   :
            begin
               wr_mask = 1'b0;
               wr_ctrl = 1'b0;
            end
         endcase
      end
   end

   // mask register
   // everything disabled out of reset
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         enable_mask_r <= '0;
      end
      else if (wr_mask)
      begin
         // data read as the mask view
         enable_mask_r <= csr_i.data.mask;
      end
   end

   // control register
   // only global_en is kept, reserved bits dropped
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         global_en_r <= 1'b0;
      end
      else if (wr_ctrl)
      begin
         global_en_r <= csr_i.data.ctrl.global_en;
      end
   end

   assign enable_mask_o = enable_mask_r;
   assign global_en_o   = global_en_r;

   // a strobe needs a clean address
   a_addr_known : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      csr_i.we |-> !$isunknown(csr_i.addr)
   ) else $error("irq_csr: write strobe with unknown address");

endmodule : irq_csr

`default_nettype wire

//--- src/irq_present.sv
`timescale 1ns/1ps
`default_nettype none

// output stage
// captures the picked id, holds it until acknowledge
// and turns the ack into a one-hot pending clear
module irq_present
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   // a pick is available
   input  logic                         any_i,
   // encoded id of the pick
   input  logic [irq_pkg::IRQ_ID_W-1:0] id_i,
   // single cycle acknowledge
   input  logic                         ack_i,
   output logic [irq_pkg::NUM_IRQ-1:0]  clear_o,
   output irq_pkg::irq_out_t            irq_o
);

   import irq_pkg::*;

   irq_out_t irq_r;
   // ack only counts while something is presented
   logic     ack_hit;

   assign ack_hit = ack_i && irq_r.valid;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         irq_r <= '0;
      end
      else if (!irq_r.valid)
      begin
         // idle, take the current pick
         if (any_i)
         begin
            irq_r.valid <= 1'b1;
            irq_r.id    <= id_i;
         end
      end
      else if (ack_hit)
      begin
         // drop the level, id back to zero while idle
         irq_r <= '0;
      end
   end

   // decode the held id into a clear for irq_pending
   // lands at the same edge valid falls
   always_comb
   begin
      clear_o = '0;
      if (ack_hit)
      begin
         clear_o[irq_r.id] = 1'b1;
      end
   end

   assign irq_o = irq_r;

   // presented id must not move until acknowledged
   a_id_held : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (irq_r.valid && !ack_i) |=> (irq_r.valid && $stable(irq_r.id))
   ) else $error("irq_present: id changed before acknowledge");

endmodule : irq_present

`default_nettype wire

//--- src/irq_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

// interrupt controller top
// csr -> pending -> pick -> encode -> present
module irq_ctrl_top
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // request pulses, one per source
   input  logic [irq_pkg::NUM_IRQ-1:0] src_i,
   // configuration write
   input  irq_pkg::csr_wr_t            csr_i,
   // acknowledge pulse
   input  logic                        ack_i,
   output irq_pkg::irq_out_t           irq_o
);

   import irq_pkg::*;

   // configuration state
   logic [NUM_IRQ-1:0]  enable_mask;
   logic                global_en;

   // sticky requests and their clear
   logic [NUM_IRQ-1:0]  pending;
   logic [NUM_IRQ-1:0]  clear;

   // pick result
   logic [NUM_IRQ-1:0]  grant;
   logic                grant_any;
   logic [IRQ_ID_W-1:0] grant_id;

   irq_csr u_csr
   (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .csr_i         (csr_i),
      .enable_mask_o (enable_mask),
      .global_en_o   (global_en)
   );

   irq_pending u_pending
   (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .src_i     (src_i),
      .clear_i   (clear),
      .pending_o (pending)
   );

   priority_pick #(.width_p(NUM_IRQ)) u_pick
   (
      .pending_i   (pending),
      .enable_i    (enable_mask),
      .global_en_i (global_en),
      .grant_o     (grant),
      .any_o       (grant_any)
   );

   // encoder valid repeats the pick's any flag
   encode_one_hot #(.width_p(NUM_IRQ)) u_encode
   (
      .i      (grant),
      .addr_o (grant_id),
      .v_o    ()
   );

   irq_present u_present
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .any_i    (grant_any),
      .id_i     (grant_id),
      .ack_i    (ack_i),
      .clear_o  (clear),
      .irq_o    (irq_o)
   );

endmodule : irq_ctrl_top

`default_nettype wire

//--- test/irq_tb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for irq_ctrl_top
// directed table, per source sweep, then random traffic against a model
module irq_tb;

   import irq_pkg::*;

   // one table row
   // exp is irq_o once the row's inputs have been sampled
   typedef struct packed
   {
      csr_wr_t            csr;
      logic [NUM_IRQ-1:0] src;
      logic               ack;
      irq_out_t           exp;
   } step_t;

   localparam int NUM_STEPS   = 36;
   localparam int VALID_LIMIT = 8;
   localparam int RAND_CYCLES = 300;

   logic               clk_i;
   logic               arst_n_i;
   logic [NUM_IRQ-1:0] src_i;
   csr_wr_t            csr_i;
   logic               ack_i;
   irq_out_t           irq_o;

   step_t              tbl [NUM_STEPS];

   // reference model state
   logic [NUM_IRQ-1:0] m_pend;
   logic [NUM_IRQ-1:0] m_mask;
   logic               m_gen;
   irq_out_t           m_out;
   logic               m_prev;
   logic               dut_prev;

   // presented ids in order, dut and model side
   logic [IRQ_ID_W-1:0] dut_ids[$];
   logic [IRQ_ID_W-1:0] model_ids[$];

   int errors;
   int checks;
   int tests_passed;
   int tests_failed;

   irq_ctrl_top DUT
   (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .src_i    (src_i),
      .csr_i    (csr_i),
      .ack_i    (ack_i),
      .irq_o    (irq_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // hard stop if something hangs
   initial
   begin
      #20000;
      $display("watchdog: simulation ran past its time limit");
      $display("STATUS: FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic csr_wr_t csr_none();
      return '0;
   endfunction

   function automatic csr_wr_t csr_mask(input logic [NUM_IRQ-1:0] m);
      csr_wr_t c;
      c           = '0;
      c.we        = 1'b1;
      c.addr      = ADDR_MASK;
      c.data.mask = m;
      return c;
   endfunction

   function automatic csr_wr_t csr_ctrl(input logic en);
      csr_wr_t c;
      c                     = '0;
      c.we                  = 1'b1;
      c.addr                = ADDR_CTRL;
      c.data.ctrl.global_en = en;
      return c;
   endfunction

   function automatic step_t make_step(input csr_wr_t c, input logic [NUM_IRQ-1:0] s,
                                       input logic a, input logic v,
                                       input logic [IRQ_ID_W-1:0] id);
      step_t st;
      st.csr       = c;
      st.src       = s;
      st.ack       = a;
      st.exp.valid = v;
      st.exp.id    = id;
      return st;
   endfunction

   // lowest numbered set bit, scanned from the top
   function automatic logic [IRQ_ID_W-1:0] lowest_id(input logic [NUM_IRQ-1:0] v);
      logic [IRQ_ID_W-1:0] id;
      id = '0;
      for (int b = NUM_IRQ - 1; b >= 0; b--)
      begin
         if (v[b])
         begin
            id = IRQ_ID_W'(b);
         end
      end
      return id;
   endfunction

   task automatic check_out(input irq_out_t got, input irq_out_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s at %0t: got 0x%h exp 0x%h", what, $time, got, exp);
      end
   endtask

   task automatic check_id(input logic [IRQ_ID_W-1:0] got, input logic [IRQ_ID_W-1:0] exp,
                           input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s at %0t: got 0x%h exp 0x%h", what, $time, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("FAIL %s: got 0x%0h exp 0x%0h", what, got, exp);
      end
   endtask

   // advance the model by one edge with the given inputs
   task automatic model_step(input csr_wr_t c, input logic [NUM_IRQ-1:0] s, input logic a);
      logic [NUM_IRQ-1:0] clr;
      logic [NUM_IRQ-1:0] elig;
      irq_out_t           nxt;
      clr  = '0;
      elig = m_pend & m_mask & {NUM_IRQ{m_gen}};
      nxt  = m_out;
      // ack only counts while presenting
      if (m_out.valid && a)
      begin
         clr[m_out.id] = 1'b1;
      end
      if (!m_out.valid)
      begin
         if (elig != '0)
         begin
            nxt.valid = 1'b1;
            nxt.id    = lowest_id(elig);
         end
      end
      else if (a)
      begin
         nxt = '0;
      end
      // a new pulse beats its own clear
      m_pend = (m_pend & ~clr) | s;
      if (c.we && c.addr == ADDR_MASK)
      begin
         m_mask = c.data.mask;
      end
      if (c.we && c.addr == ADDR_CTRL)
      begin
         m_gen = c.data.ctrl.global_en;
      end
      m_out = nxt;
   endtask

   // one clock: drive, check the previous edge's result, then step the model
   task automatic tick(input csr_wr_t c, input logic [NUM_IRQ-1:0] s, input logic a);
      @(posedge clk_i);
      csr_i <= c;
      src_i <= s;
      ack_i <= a;
      @(negedge clk_i);
      check_out(irq_o, m_out, "irq_o vs model");
      if (irq_o.valid && !dut_prev)
      begin
         dut_ids.push_back(irq_o.id);
      end
      if (m_out.valid && !m_prev)
      begin
         model_ids.push_back(m_out.id);
      end
      dut_prev = irq_o.valid;
      m_prev   = m_out.valid;
      model_step(c, s, a);
   endtask

   task automatic run_table(input int first, input int last);
      for (int i = first; i <= last; i++)
      begin
         tick(tbl[i].csr, tbl[i].src, tbl[i].ack);
         if (i > first)
         begin
            check_out(irq_o, tbl[i-1].exp, $sformatf("irq_o step %0d", i - 1));
         end
      end
      tick(csr_none(), '0, 1'b0);
      check_out(irq_o, tbl[last].exp, $sformatf("irq_o step %0d", last));
   endtask

   // bounded wait for the interrupt level
   task automatic wait_valid(output int cycles);
      cycles = 0;
      while (!irq_o.valid && cycles < VALID_LIMIT)
      begin
         tick(csr_none(), '0, 1'b0);
         cycles++;
      end
      if (!irq_o.valid)
      begin
         errors++;
         $display("timeout: irq_o.valid did not rise within %0d cycles", VALID_LIMIT);
      end
   endtask

   task automatic finish_test(input string name, input int errs_at_start);
      if (errors == errs_at_start)
      begin
         tests_passed++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errs_at_start);
      end
   endtask

   initial
   begin
      int                 errs_at;
      int                 lat;
      logic [31:0]        rng;
      csr_wr_t            rcsr;
      logic [NUM_IRQ-1:0] rsrc;

      errors       = 0;
      checks       = 0;
      tests_passed = 0;
      tests_failed = 0;
      arst_n_i     = 1'b0;
      src_i        = '0;
      csr_i        = '0;
      ack_i        = 1'b0;
      m_pend       = '0;
      m_mask       = '0;
      m_gen        = 1'b0;
      m_out        = '0;
      m_prev       = 1'b0;
      dut_prev     = 1'b0;

      // reset idle, pulse with global enable off
      tbl[0]  = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[1]  = make_step(csr_mask(16'hffff), 16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[2]  = make_step(csr_none(),        16'h0008, 1'b0, 1'b0, 4'd0);
      tbl[3]  = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      // source 3 stays pending behind its mask bit
      tbl[4]  = make_step(csr_mask(16'hfff7), 16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[5]  = make_step(csr_ctrl(1'b1),    16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[6]  = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[7]  = make_step(csr_mask(16'hffff), 16'h0000, 1'b0, 1'b0, 4'd0);
      tbl[8]  = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd3);
      tbl[9]  = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[10] = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      // id 8 held while source 1 arrives
      tbl[11] = make_step(csr_none(),        16'h0100, 1'b0, 1'b0, 4'd0);
      tbl[12] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd8);
      tbl[13] = make_step(csr_none(),        16'h0002, 1'b0, 1'b1, 4'd8);
      tbl[14] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd8);
      tbl[15] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[16] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd1);
      tbl[17] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[18] = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      // sources 2, 5, 9, 14 at once
      tbl[19] = make_step(csr_none(),        16'h4224, 1'b0, 1'b0, 4'd0);
      tbl[20] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd2);
      tbl[21] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[22] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd5);
      tbl[23] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[24] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd9);
      tbl[25] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[26] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd14);
      tbl[27] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      // stray ack while idle does nothing
      tbl[28] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[29] = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);
      // pulse in the clearing cycle keeps the bit
      tbl[30] = make_step(csr_none(),        16'h0010, 1'b0, 1'b0, 4'd0);
      tbl[31] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd4);
      tbl[32] = make_step(csr_none(),        16'h0010, 1'b1, 1'b0, 4'd0);
      tbl[33] = make_step(csr_none(),        16'h0000, 1'b0, 1'b1, 4'd4);
      tbl[34] = make_step(csr_none(),        16'h0000, 1'b1, 1'b0, 4'd0);
      tbl[35] = make_step(csr_none(),        16'h0000, 1'b0, 1'b0, 4'd0);

      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;

      errs_at = errors;
      run_table(0, 3);
      finish_test("reset_and_global_disable", errs_at);
      errs_at = errors;
      run_table(4, 10);
      finish_test("mask_hides_pending", errs_at);
      errs_at = errors;
      run_table(11, 18);
      finish_test("held_id", errs_at);
      errs_at = errors;
      run_table(19, 29);
      finish_test("priority_order", errs_at);
      errs_at = errors;
      run_table(30, 35);
      finish_test("set_beats_clear", errs_at);

      // every source through the encoder, two cycle latency
      errs_at = errors;
      for (int k = 0; k < NUM_IRQ; k++)
      begin
         tick(csr_none(), NUM_IRQ'(1) << k, 1'b0);
         wait_valid(lat);
         check_count(lat, 2, $sformatf("latency of source %0d", k));
         check_id(irq_o.id, IRQ_ID_W'(k), "irq_o.id");
         tick(csr_none(), '0, 1'b1);
      end
      finish_test("single_source_sweep", errs_at);

      // random pulses, acks and rare mask changes
      errs_at = errors;
      rng     = 32'h8c7c_40e4;
      dut_ids.delete();
      model_ids.delete();
      for (int n = 0; n < RAND_CYCLES; n++)
      begin
         rng  = xorshift32(rng);
         rcsr = csr_none();
         if (rng[31:28] == 4'hf)
         begin
            rcsr = csr_mask(rng[15:0] | 16'h8001);
         end
         rsrc = rng[15:0] & rng[31:16] & rng[23:8];
         tick(rcsr, rsrc, rng[26]);
      end
      // open every mask bit and drain with steady acks
      tick(csr_mask(16'hffff), '0, 1'b0);
      repeat (40) tick(csr_none(), '0, 1'b1);
      check_count(dut_ids.size(), model_ids.size(), "presented id count");
      for (int n = 0; n < dut_ids.size() && n < model_ids.size(); n++)
      begin
         check_id(dut_ids[n], model_ids[n], $sformatf("presented id %0d", n));
      end
      finish_test("random_traffic", errs_at);

      $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, checks, errors);
      if (errors == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule : irq_tb

`default_nettype wire

//--- vlog.f
src/irq_pkg.sv
src/encode_one_hot.sv
src/priority_pick.sv
src/irq_pending.sv
src/irq_csr.sv
src/irq_present.sv
src/irq_ctrl_top.sv
test/irq_tb.sv
